// ==== src/vpu_defs.svh ====
`ifndef VPU_DEFS_SVH
`define VPU_DEFS_SVH

// operand word, ieee-754 single precision.
`define VPU_OPERAND_WIDTH    32

// one valid bit per source read port.
`define VPU_SRAM_R_PORT_CNT  3

`define VPU_CMP_LATENCY      2
`define VPU_DST_ADDR_WIDTH   8

`endif

// ==== src/vpu_fp_pkg.sv ====
`include "vpu_defs.svh"

package vpu_fp_pkg;

    // field view of a single precision word.
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp32_fields_t;

    // same word, seen as raw bits or as fields.
    typedef union packed {
        logic [`VPU_OPERAND_WIDTH-1:0] raw;
        fp32_fields_t                  f;
    } fp32_t;

endpackage

// ==== src/vpu_ctrl_pkg.sv ====
package vpu_ctrl_pkg;

    // max over op_0/op_1, or over all three.
    typedef enum logic {
        MODE_MAX2 = 1'b0,
        MODE_MAX3 = 1'b1
    } op_mode_t;

    // source operand index, 0 to 2.
    typedef logic [1:0] op_idx_t;

endpackage

// ==== src/vpu_operand_if.sv ====
`timescale 1ns/1ns

interface vpu_operand_if
    import vpu_fp_pkg::*, vpu_ctrl_pkg::*;
    ();

    logic     valid;                    // one cycle per item.
    fp32_t    a;
    fp32_t    b;
    fp32_t    c;                        // third operand, rides along.
    op_mode_t mode;
    op_idx_t  idx_a;
    op_idx_t  idx_b;

    modport src (
        output valid, a, b, c, mode, idx_a, idx_b
    );

    modport sink (
        input  valid, a, b, c, mode, idx_a, idx_b
    );

endinterface

// ==== src/vpu_src_port.sv ====
`timescale 1ns/1ns
`include "vpu_defs.svh"

module vpu_src_port
    import vpu_fp_pkg::*, vpu_ctrl_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  fp32_t                           op_0,
    input  fp32_t                           op_1,
    input  fp32_t                           op_2,
    input  logic [`VPU_SRAM_R_PORT_CNT-1:0] op_valid,
    input  logic                            start,
    output logic                            reject,
    vpu_operand_if.src                      out
);

    logic well_formed;
    logic bad_q;

    // op_0 and op_1 are mandatory.
    assign well_formed = op_valid[0] & op_valid[1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
            bad_q     <= 1'b0;
            reject    <= 1'b0;
        end else begin
            out.valid <= start & well_formed;
            bad_q     <= start & ~well_formed;
            reject    <= bad_q;                     // one cycle behind the item.
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            out.a     <= op_0;
            out.b     <= op_1;
            out.c     <= op_2;
            out.mode  <= op_valid[`VPU_SRAM_R_PORT_CNT-1] ? MODE_MAX3 : MODE_MAX2;
            out.idx_a <= 2'd0;
            out.idx_b <= 2'd1;
        end
    end

endmodule

// ==== src/fp_cmp_stage.sv ====
`timescale 1ns/1ns
`include "vpu_defs.svh"

module fp_cmp_stage
    import vpu_fp_pkg::*, vpu_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    vpu_operand_if.sink  in,
    input  logic         bypass,
    vpu_operand_if.src   out
);

    logic [`VPU_CMP_LATENCY-1:0]   vld_sr;
    logic [`VPU_OPERAND_WIDTH-1:0] key_a_q;
    logic [`VPU_OPERAND_WIDTH-1:0] key_b_q;
    logic                          nan_a_q;
    logic                          nan_b_q;
    logic                          byp_q;
    fp32_t                         a_q;
    fp32_t                         b_q;
    fp32_t                         c_q;
    op_mode_t                      mode_q;
    op_idx_t                       idx_a_q;
    op_idx_t                       idx_b_q;
    logic                          a_wins;

    function automatic logic is_nan(input fp32_t v);
        return (v.f.exponent == 8'hff) && (v.f.mantissa != '0);
    endfunction

    // unsigned key that orders like the float value.
    function automatic logic [`VPU_OPERAND_WIDTH-1:0] sort_key(input fp32_t v);
        if (v.f.exponent == '0 && v.f.mantissa == '0)
            return {1'b1, {(`VPU_OPERAND_WIDTH-1){1'b0}}};  // both zeros map to +0.
        else if (v.f.sign)
            return {1'b0, ~v.raw[`VPU_OPERAND_WIDTH-2:0]};
        else
            return {1'b1, v.raw[`VPU_OPERAND_WIDTH-2:0]};
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[`VPU_CMP_LATENCY-2:0], in.valid};
        end
    end

    assign out.valid = vld_sr[`VPU_CMP_LATENCY-1];

    // decode.
    always_ff @(posedge clk) begin
        if (in.valid) begin
            key_a_q <= sort_key(in.a);
            key_b_q <= sort_key(in.b);
            nan_a_q <= is_nan(in.a);
            nan_b_q <= is_nan(in.b);
            byp_q   <= bypass;
            a_q     <= in.a;
            b_q     <= in.b;
            c_q     <= in.c;
            mode_q  <= in.mode;
            idx_a_q <= in.idx_a;
            idx_b_q <= in.idx_b;
        end
    end

    // a sits at the lower index, so it keeps ties and nan pairs.
    assign a_wins = byp_q | nan_b_q | (~nan_a_q & (key_a_q >= key_b_q));

    // resolve.
    always_ff @(posedge clk) begin
        if (vld_sr[0]) begin
            out.a     <= a_wins ? a_q : b_q;
            out.idx_a <= a_wins ? idx_a_q : idx_b_q;
            out.b     <= a_wins ? b_q : a_q;        // loser.
            out.idx_b <= a_wins ? idx_b_q : idx_a_q;
            out.c     <= c_q;
            out.mode  <= mode_q;
        end
    end

endmodule

// ==== src/vpu_fp_max.sv ====
`timescale 1ns/1ns

module vpu_fp_max
    import vpu_fp_pkg::*, vpu_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    vpu_operand_if.sink in,
    output logic        res_valid,
    output fp32_t       res_value,
    output op_idx_t     res_idx
);

    vpu_operand_if c0_out ();
    vpu_operand_if s2 ();
    vpu_operand_if s3 ();

    logic skip_third;

    // op_0 against op_1.
    fp_cmp_stage cmp_0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .in     (in),
        .bypass (1'b0),
        .out    (c0_out)
    );

    // winner so far against op_2.
    assign s2.valid = c0_out.valid;
    assign s2.a     = c0_out.a;
    assign s2.idx_a = c0_out.idx_a;
    assign s2.b     = c0_out.c;
    assign s2.idx_b = 2'd2;
    assign s2.c     = c0_out.c;
    assign s2.mode  = c0_out.mode;

    // two-operand items still pass cmp_1, so latency stays fixed.
    assign skip_third = (s2.mode == MODE_MAX2);

    fp_cmp_stage cmp_1 (
        .clk    (clk),
        .rst_n  (rst_n),
        .in     (s2),
        .bypass (skip_third),
        .out    (s3)
    );

    assign res_valid = s3.valid;
    assign res_value = s3.a;
    assign res_idx   = s3.idx_a;

endmodule

// ==== src/vpu_dst_port.sv ====
`timescale 1ns/1ns
`include "vpu_defs.svh"

module vpu_dst_port
    import vpu_ctrl_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           clear,
    input  logic                           res_valid,
    input  logic [`VPU_OPERAND_WIDTH-1:0]  res_value,
    input  op_idx_t                        res_idx,
    output logic [`VPU_OPERAND_WIDTH-1:0]  result,
    output op_idx_t                        result_idx,
    output logic [`VPU_DST_ADDR_WIDTH-1:0] wr_addr,
    output logic                           wr_en
);

    logic [`VPU_DST_ADDR_WIDTH-1:0] addr_cnt;
    logic [`VPU_DST_ADDR_WIDTH-1:0] addr_now;

    // clear takes effect on a result in the same cycle.
    assign addr_now = clear ? '0 : addr_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_cnt <= '0;
            wr_addr  <= '0;
            wr_en    <= 1'b0;
        end else begin
            wr_en <= res_valid;
            if (res_valid) begin
                wr_addr  <= addr_now;
                addr_cnt <= addr_now + 1'b1;        // wraps at 256.
            end else if (clear) begin
                addr_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            result     <= res_value;
            result_idx <= res_idx;
        end
    end

endmodule

// ==== src/vpu_fp_max_top.sv ====
`timescale 1ns/1ns
`include "vpu_defs.svh"

module vpu_fp_max_top
    import vpu_fp_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [`VPU_OPERAND_WIDTH-1:0]   op_0,
    input  logic [`VPU_OPERAND_WIDTH-1:0]   op_1,
    input  logic [`VPU_OPERAND_WIDTH-1:0]   op_2,
    input  logic [`VPU_SRAM_R_PORT_CNT-1:0] op_valid,
    input  logic                            start,
    input  logic                            clear,
    output logic [`VPU_OPERAND_WIDTH-1:0]   result,
    output logic [1:0]                      result_idx,
    output logic [`VPU_DST_ADDR_WIDTH-1:0]  wr_addr,
    output logic                            wr_en,
    output logic                            reject
);

    vpu_operand_if s1 ();

    logic       max_valid;
    fp32_t      max_value;
    logic [1:0] max_idx;

    vpu_src_port u_src_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_0     (op_0),
        .op_1     (op_1),
        .op_2     (op_2),
        .op_valid (op_valid),
        .start    (start),
        .reject   (reject),
        .out      (s1)
    );

    vpu_fp_max u_fp_max (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (s1),
        .res_valid (max_valid),
        .res_value (max_value),
        .res_idx   (max_idx)
    );

    vpu_dst_port u_dst_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .res_valid  (max_valid),
        .res_value  (max_value),
        .res_idx    (max_idx),
        .result     (result),
        .result_idx (result_idx),
        .wr_addr    (wr_addr),
        .wr_en      (wr_en)
    );

endmodule

// ==== sim/vpu_fp_max_asserts.sv ====
`timescale 1ns/1ns

module vpu_fp_max_asserts (
    input logic       clk,
    input logic       rst_n,
    input logic       start,
    input logic       clear,
    input logic [2:0] op_valid,
    input logic       wr_en,
    input logic       reject,
    input logic [7:0] wr_addr
);

    logic well_formed;
    int   fail_cnt;

    assign well_formed = op_valid[0] & op_valid[1];

    a_no_write_in_reset: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> !wr_en)
        else begin
            $error("wr_en high during reset");
            fail_cnt++;
        end

    // wr_en rises on edge 5, seen by the sampling edge after it.
    a_start_to_write: assert property (@(posedge clk) disable iff (!rst_n)
        (start && well_formed) |-> ##6 wr_en)
        else begin
            $error("accepted request gave no write");
            fail_cnt++;
        end

    a_bad_rejects: assert property (@(posedge clk) disable iff (!rst_n)
        (start && !well_formed) |-> ##2 reject)
        else begin
            $error("malformed request not rejected");
            fail_cnt++;
        end

    a_good_never_rejects: assert property (@(posedge clk) disable iff (!rst_n)
        (start && well_formed) |-> ##2 !reject)
        else begin
            $error("well-formed request rejected");
            fail_cnt++;
        end

    a_addr_steps: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_en && $past(wr_en) && !$past(clear)) |-> wr_addr == 8'($past(wr_addr) + 1))
        else begin
            $error("wr_addr did not step by one");
            fail_cnt++;
        end

endmodule

bind vpu_fp_max_top vpu_fp_max_asserts u_asserts (
    .clk(clk), .rst_n(rst_n), .start(start), .clear(clear), .op_valid(op_valid),
    .wr_en(wr_en), .reject(reject), .wr_addr(wr_addr)
);

// ==== sim/vpu_fp_max_tb.sv ====
`timescale 1ns/1ns

module vpu_fp_max_tb
    import vpu_fp_pkg::*;
();

    typedef struct {
        logic [31:0] a, b, c, val;
        logic [2:0]  mask;
        logic [1:0]  idx;
        int          gap;
    } row_t;
    typedef struct {
        logic [31:0] val;
        logic [1:0]  idx;
    } exp_t;

    logic clk, rst_n, start, clear, wr_en, reject;
    logic [31:0] op_0, op_1, op_2, result;
    logic [2:0]  op_valid;
    logic [1:0]  result_idx;
    logic [7:0]  wr_addr, exp_addr;
    row_t rows[$];
    exp_t exp_q[$];
    int   rej_exp, rej_seen, gaps_total;
    bit   table_ready;

    vpu_fp_max_top UUT (.*);

    always #2 clk = ~clk;

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, msg, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    function automatic bit is_nan_ref(input fp32_t v);
        return v.f.exponent == 8'hff && v.f.mantissa != 0;
    endfunction

    // strict x > y for two numbers; signed zeros are equal.
    function automatic bit greater(input fp32_t x, input fp32_t y);
        if (x.raw[30:0] == 0 && y.raw[30:0] == 0) return 0;
        if (x.f.sign != y.f.sign) return y.f.sign;
        if (!x.f.sign) return x.raw[30:0] > y.raw[30:0];
        return x.raw[30:0] < y.raw[30:0];
    endfunction

    task automatic model(input fp32_t a, b, c, input logic [2:0] mask,
                         output logic [31:0] val, output logic [1:0] idx);
        fp32_t best;
        best = a;
        idx = 0;
        if (!is_nan_ref(b) && (is_nan_ref(best) || greater(b, best))) begin
            best = b;
            idx = 1;
        end
        if (mask[2] && !is_nan_ref(c) && (is_nan_ref(best) || greater(c, best))) begin
            best = c;
            idx = 2;
        end
        val = best.raw;
    endtask

    task automatic add_row(input logic [31:0] a, b, c, input logic [2:0] mask,
                           input logic [31:0] val, input logic [1:0] idx, input int gap);
        row_t r;
        r = '{a: a, b: b, c: c, val: val, mask: mask, idx: idx, gap: gap};
        rows.push_back(r);
        gaps_total += gap;
    endtask

    function automatic logic [31:0] pick_operand();
        logic [31:0] pool [8] = '{32'h0, 32'h80000000, 32'h7f800000, 32'hff800000,
                                  32'h7fc00000, 32'h3f800000, 32'h00000001, 32'hbf800000};
        if ($urandom % 4 == 0) return pool[$urandom % 8];
        return $urandom;
    endfunction

    task automatic build_table();
        logic [31:0] a, b, c, v;
        logic [2:0]  m;
        logic [1:0]  ix;
        add_row(32'h3f800000, 32'h40000000, 32'h40400000, 3'b111, 32'h40400000, 2, 0);
        add_row(32'h40400000, 32'h40000000, 32'h3f800000, 3'b111, 32'h40400000, 0, 0);
        add_row(32'hbf800000, 32'hc0000000, 32'hc0400000, 3'b111, 32'hbf800000, 0, 0);
        add_row(32'hc0400000, 32'hbf800000, 32'hc0000000, 3'b111, 32'hbf800000, 1, 0);
        add_row(32'h80000000, 32'h00000000, 32'hbf800000, 3'b111, 32'h80000000, 0, 0);
        add_row(32'h00000000, 32'h80000000, 32'h80000000, 3'b111, 32'h00000000, 0, 0);
        add_row(32'h7fc00000, 32'h3f800000, 32'hbf800000, 3'b111, 32'h3f800000, 1, 0);
        add_row(32'h7fc00000, 32'h7fc00001, 32'h7f800001, 3'b111, 32'h7fc00000, 0, 0);
        add_row(32'h7fc00000, 32'h7fa00000, 32'hc0000000, 3'b111, 32'hc0000000, 2, 0);
        add_row(32'h40000000, 32'h40000000, 32'h40000000, 3'b111, 32'h40000000, 0, 0);
        add_row(32'h3f800000, 32'h40000000, 32'h40000000, 3'b111, 32'h40000000, 1, 0);
        add_row(32'h7f800000, 32'h7f7fffff, 32'h7fc00000, 3'b111, 32'h7f800000, 0, 0);
        add_row(32'hff800000, 32'hff7fffff, 32'hff800000, 3'b111, 32'hff7fffff, 1, 0);
        add_row(32'h00000001, 32'h00000002, 32'h807fffff, 3'b111, 32'h00000002, 1, 0);
        add_row(32'h00800000, 32'h007fffff, 32'h00000000, 3'b111, 32'h00800000, 0, 0);
        add_row(32'h3f800000, 32'h40000000, 32'h7f800000, 3'b011, 32'h40000000, 1, 0);
        add_row(32'h40000000, 32'h3f800000, 32'h7f800000, 3'b011, 32'h40000000, 0, 0);
        add_row(32'h7fc00000, 32'h7fc00000, 32'h3f800000, 3'b011, 32'h7fc00000, 0, 0);
        add_row(32'h00000000, 32'h80000000, 32'h40000000, 3'b011, 32'h00000000, 0, 0);
        add_row(32'h3f800000, 32'h40000000, 32'h40400000, 3'b101, 32'h0, 0, 0);
        add_row(32'h3f800000, 32'h40000000, 32'h40400000, 3'b110, 32'h0, 0, 0);
        add_row(32'h3f800000, 32'h40000000, 32'h40400000, 3'b000, 32'h0, 0, 0);
        for (int i = 0; i < 200; i++) begin
            a = pick_operand();
            b = pick_operand();
            c = pick_operand();
            m = $urandom % 8;
            if ($urandom % 4 != 0) m[1:0] = 2'b11;
            model(a, b, c, m, v, ix);
            add_row(a, b, c, m, v, ix, (i >= 100 && $urandom % 3 == 0) ? 1 + $urandom % 2 : 0);
        end
    endtask

    // response checker.
    always @(negedge clk) begin
        exp_t e;
        if (UUT.u_asserts.fail_cnt != 0) begin
            $display("a bound assertion on the DUT failed");
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
        if (rst_n && reject) rej_seen++;
        if (rst_n && wr_en) begin
            if (exp_q.size() == 0) begin
                $display("write strobe arrived with no request outstanding");
                $display("TEST RESULT: FAIL");
                $fatal(1);
            end
            e = exp_q.pop_front();
            check_eq(result, e.val, "result");
            check_eq(result_idx, e.idx, "result_idx");
            check_eq(wr_addr, exp_addr, "wr_addr");
            exp_addr = exp_addr + 1;
        end
    end

    initial begin
        wait (table_ready);
        #((rows.size() + gaps_total + 64) * 4);
        $display("timeout: outputs stopped arriving before all requests completed");
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'h18b0a999));
        {clk, rst_n, start, clear, op_0, op_1, op_2, op_valid} = '0;
        exp_addr = 0;
        build_table();
        table_ready = 1;
        repeat (16) @(negedge clk);
        rst_n = 1;
        foreach (rows[i]) begin
            if (i == 122) begin
                @(negedge clk);
                start = 0;
                drain();
                clear = 1;
                @(negedge clk);
                clear = 0;
                exp_addr = 0;                   // counter restarts.
            end
            @(negedge clk);
            {op_0, op_1, op_2} = {rows[i].a, rows[i].b, rows[i].c};
            {op_valid, start} = {rows[i].mask, 1'b1};
            if (rows[i].mask[1:0] == 2'b11) exp_q.push_back('{val: rows[i].val, idx: rows[i].idx});
            else rej_exp++;
            repeat (rows[i].gap) begin
                @(negedge clk);
                start = 0;
            end
        end
        @(negedge clk);
        start = 0;
        drain();
        if (rej_seen == rej_exp && exp_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("reject count %0d does not match expected %0d", rej_seen, rej_exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

endmodule

// ==== vpu_fp_max_top.f ====
+incdir+src
src/vpu_fp_pkg.sv
src/vpu_ctrl_pkg.sv
src/vpu_operand_if.sv
src/vpu_src_port.sv
src/fp_cmp_stage.sv
src/vpu_fp_max.sv
src/vpu_dst_port.sv
src/vpu_fp_max_top.sv
sim/vpu_fp_max_asserts.sv
sim/vpu_fp_max_tb.sv
